// File: build.f
hw/isa_pkg.sv
hw/core_pkg.sv
hw/inst_decode.sv
hw/decode_queue.sv
hw/exec_unit.sv
hw/core_top.sv
tests/tb_core_top.sv

// File: hw/core_pkg.sv
// Core machine constants
package core_pkg;

  localparam int XLEN       = 64;
  localparam int REG_ADDR_W = 5;
  localparam int NUM_REGS   = 32;

  localparam logic [XLEN-1:0] DEF_RESET_PC    = 64'h0000_0000_8000_0000;
  localparam int              DEF_QUEUE_DEPTH = 4;

  // One decoded instruction as stored in the queue
  localparam int DEC_W = XLEN
                       + 3 * REG_ADDR_W
                       + isa_pkg::ALU_OP_W
                       + isa_pkg::BRANCH_W
                       + isa_pkg::MEM_OP_W
                       + isa_pkg::A_SRC_W
                       + isa_pkg::B_SRC_W
                       + 3; // reg_wr, mem_wr, mem_rd

endpackage

// File: hw/core_top.sv
// RV64I execution slice top
module core_top
  import isa_pkg::*;
  import core_pkg::*;
#(
  parameter logic [XLEN-1:0] RESET_PC    = DEF_RESET_PC,
  parameter int              QUEUE_DEPTH = DEF_QUEUE_DEPTH
) (
  input  logic                  i_clk,
  input  logic                  i_rst_n,
  input  logic [INST_W-1:0]     i_inst,
  input  logic                  i_inst_valid,
  output logic                  o_ready,
  output logic                  o_retire,
  output logic [XLEN-1:0]       o_retire_pc,
  output logic                  o_wb_en,
  output logic [REG_ADDR_W-1:0] o_wb_rd,
  output logic [XLEN-1:0]       o_wb_data,
  output logic                  o_mem_wr,
  output logic                  o_mem_rd,
  output logic [XLEN-1:0]       o_mem_addr,
  output logic [XLEN-1:0]       o_mem_wdata,
  output mem_op_e               o_mem_op,
  output logic                  o_halt
);

  logic                  dec_valid;
  logic [XLEN-1:0]       dec_imm;
  logic [REG_ADDR_W-1:0] dec_ra;
  logic [REG_ADDR_W-1:0] dec_rb;
  logic [REG_ADDR_W-1:0] dec_rd;
  alu_op_e               dec_alu_op;
  branch_e               dec_branch;
  mem_op_e               dec_mem_op;
  a_src_e                dec_a_src;
  b_src_e                dec_b_src;
  logic                  dec_reg_wr;
  logic                  dec_mem_wr;
  logic                  dec_mem_rd;

  logic                  not_empty;
  logic                  pop;
  logic [XLEN-1:0]       q_imm;
  logic [REG_ADDR_W-1:0] q_ra;
  logic [REG_ADDR_W-1:0] q_rb;
  logic [REG_ADDR_W-1:0] q_rd;
  alu_op_e               q_alu_op;
  branch_e               q_branch;
  mem_op_e               q_mem_op;
  a_src_e                q_a_src;
  b_src_e                q_b_src;
  logic                  q_reg_wr;
  logic                  q_mem_wr;
  logic                  q_mem_rd;

  inst_decode u_decode (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_inst       (i_inst),
    .i_inst_valid (i_inst_valid),
    .o_dec_valid  (dec_valid),
    .o_imm        (dec_imm),
    .o_ra         (dec_ra),
    .o_rb         (dec_rb),
    .o_rd         (dec_rd),
    .o_alu_op     (dec_alu_op),
    .o_branch     (dec_branch),
    .o_mem_op     (dec_mem_op),
    .o_a_src      (dec_a_src),
    .o_b_src      (dec_b_src),
    .o_reg_wr     (dec_reg_wr),
    .o_mem_wr     (dec_mem_wr),
    .o_mem_rd     (dec_mem_rd)
  );

  decode_queue #(
    .DEPTH (QUEUE_DEPTH)
  ) u_queue (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_push      (dec_valid),
    .i_imm       (dec_imm),
    .i_ra        (dec_ra),
    .i_rb        (dec_rb),
    .i_rd        (dec_rd),
    .i_alu_op    (dec_alu_op),
    .i_branch    (dec_branch),
    .i_mem_op    (dec_mem_op),
    .i_a_src     (dec_a_src),
    .i_b_src     (dec_b_src),
    .i_reg_wr    (dec_reg_wr),
    .i_mem_wr    (dec_mem_wr),
    .i_mem_rd    (dec_mem_rd),
    .i_pop       (pop),
    .o_ready     (o_ready),
    .o_not_empty (not_empty),
    .o_q_imm     (q_imm),
    .o_q_ra      (q_ra),
    .o_q_rb      (q_rb),
    .o_q_rd      (q_rd),
    .o_q_alu_op  (q_alu_op),
    .o_q_branch  (q_branch),
    .o_q_mem_op  (q_mem_op),
    .o_q_a_src   (q_a_src),
    .o_q_b_src   (q_b_src),
    .o_q_reg_wr  (q_reg_wr),
    .o_q_mem_wr  (q_mem_wr),
    .o_q_mem_rd  (q_mem_rd)
  );

  exec_unit #(
    .RESET_PC (RESET_PC)
  ) u_exec (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_not_empty (not_empty),
    .i_q_imm     (q_imm),
    .i_q_ra      (q_ra),
    .i_q_rb      (q_rb),
    .i_q_rd      (q_rd),
    .i_q_alu_op  (q_alu_op),
    .i_q_branch  (q_branch),
    .i_q_mem_op  (q_mem_op),
    .i_q_a_src   (q_a_src),
    .i_q_b_src   (q_b_src),
    .i_q_reg_wr  (q_reg_wr),
    .i_q_mem_wr  (q_mem_wr),
    .i_q_mem_rd  (q_mem_rd),
    .o_pop       (pop),
    .o_retire    (o_retire),
    .o_retire_pc (o_retire_pc),
    .o_wb_en     (o_wb_en),
    .o_wb_rd     (o_wb_rd),
    .o_wb_data   (o_wb_data),
    .o_mem_wr    (o_mem_wr),
    .o_mem_rd    (o_mem_rd),
    .o_mem_addr  (o_mem_addr),
    .o_mem_wdata (o_mem_wdata),
    .o_mem_op    (o_mem_op),
    .o_halt      (o_halt)
  );

endmodule

// File: hw/decode_queue.sv
// Decoded instruction FIFO
module decode_queue
  import isa_pkg::*;
  import core_pkg::*;
#(
  parameter int DEPTH = DEF_QUEUE_DEPTH
) (
  input  logic                  i_clk,
  input  logic                  i_rst_n,
  input  logic                  i_push,
  input  logic [XLEN-1:0]       i_imm,
  input  logic [REG_ADDR_W-1:0] i_ra,
  input  logic [REG_ADDR_W-1:0] i_rb,
  input  logic [REG_ADDR_W-1:0] i_rd,
  input  alu_op_e               i_alu_op,
  input  branch_e               i_branch,
  input  mem_op_e               i_mem_op,
  input  a_src_e                i_a_src,
  input  b_src_e                i_b_src,
  input  logic                  i_reg_wr,
  input  logic                  i_mem_wr,
  input  logic                  i_mem_rd,
  input  logic                  i_pop,
  output logic                  o_ready,
  output logic                  o_not_empty,
  output logic [XLEN-1:0]       o_q_imm,
  output logic [REG_ADDR_W-1:0] o_q_ra,
  output logic [REG_ADDR_W-1:0] o_q_rb,
  output logic [REG_ADDR_W-1:0] o_q_rd,
  output alu_op_e               o_q_alu_op,
  output branch_e               o_q_branch,
  output mem_op_e               o_q_mem_op,
  output a_src_e                o_q_a_src,
  output b_src_e                o_q_b_src,
  output logic                  o_q_reg_wr,
  output logic                  o_q_mem_wr,
  output logic                  o_q_mem_rd
);

  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  typedef struct packed {
    logic [XLEN-1:0]       imm;
    logic [REG_ADDR_W-1:0] ra;
    logic [REG_ADDR_W-1:0] rb;
    logic [REG_ADDR_W-1:0] rd;
    alu_op_e               alu_op;
    branch_e               branch;
    mem_op_e               mem_op;
    a_src_e                a_src;
    b_src_e                b_src;
    logic                  reg_wr;
    logic                  mem_wr;
    logic                  mem_rd;
  } dec_t;

  logic [DEC_W-1:0] mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_push;
  logic             do_pop;
  dec_t             wr_word;
  dec_t             rd_word;

  assign o_ready     = (count != CNT_W'(DEPTH));
  assign o_not_empty = (count != '0);
  assign do_push     = i_push & o_ready;
  assign do_pop      = i_pop & o_not_empty;

  assign wr_word = '{imm: i_imm, ra: i_ra, rb: i_rb, rd: i_rd, alu_op: i_alu_op,
                     branch: i_branch, mem_op: i_mem_op, a_src: i_a_src, b_src: i_b_src,
                     reg_wr: i_reg_wr, mem_wr: i_mem_wr, mem_rd: i_mem_rd};
  assign rd_word = dec_t'(mem[rd_ptr]); // Head is visible without a read cycle

  always_ff @(posedge i_clk) begin
    if (do_push) begin
      mem[wr_ptr] <= wr_word;
    end
  end

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  assign o_q_imm    = rd_word.imm;
  assign o_q_ra     = rd_word.ra;
  assign o_q_rb     = rd_word.rb;
  assign o_q_rd     = rd_word.rd;
  assign o_q_alu_op = rd_word.alu_op;
  assign o_q_branch = rd_word.branch;
  assign o_q_mem_op = rd_word.mem_op;
  assign o_q_a_src  = rd_word.a_src;
  assign o_q_b_src  = rd_word.b_src;
  assign o_q_reg_wr = rd_word.reg_wr;
  assign o_q_mem_wr = rd_word.mem_wr;
  assign o_q_mem_rd = rd_word.mem_rd;

  a_no_push_full: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_push |-> o_ready);
  a_no_pop_empty: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_pop |-> o_not_empty);
  a_count_bound: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    count <= CNT_W'(DEPTH));

endmodule

// File: hw/exec_unit.sv
// Execute and retire stage
module exec_unit
  import isa_pkg::*;
  import core_pkg::*;
#(
  parameter logic [XLEN-1:0] RESET_PC = DEF_RESET_PC
) (
  input  logic                  i_clk,
  input  logic                  i_rst_n,
  input  logic                  i_not_empty,
  input  logic [XLEN-1:0]       i_q_imm,
  input  logic [REG_ADDR_W-1:0] i_q_ra,
  input  logic [REG_ADDR_W-1:0] i_q_rb,
  input  logic [REG_ADDR_W-1:0] i_q_rd,
  input  alu_op_e               i_q_alu_op,
  input  branch_e               i_q_branch,
  input  mem_op_e               i_q_mem_op,
  input  a_src_e                i_q_a_src,
  input  b_src_e                i_q_b_src,
  input  logic                  i_q_reg_wr,
  input  logic                  i_q_mem_wr,
  input  logic                  i_q_mem_rd,
  output logic                  o_pop,
  output logic                  o_retire,
  output logic [XLEN-1:0]       o_retire_pc,
  output logic                  o_wb_en,
  output logic [REG_ADDR_W-1:0] o_wb_rd,
  output logic [XLEN-1:0]       o_wb_data,
  output logic                  o_mem_wr,
  output logic                  o_mem_rd,
  output logic [XLEN-1:0]       o_mem_addr,
  output logic [XLEN-1:0]       o_mem_wdata,
  output mem_op_e               o_mem_op,
  output logic                  o_halt
);

  logic [XLEN-1:0] regs [NUM_REGS];
  logic [XLEN-1:0] pc;
  logic [XLEN-1:0] rs_a;
  logic [XLEN-1:0] rs_b;
  logic [XLEN-1:0] op_a;
  logic [XLEN-1:0] op_b;
  logic [XLEN-1:0] sum;
  logic [XLEN-1:0] alu_res;
  logic [XLEN-1:0] ea;
  logic [XLEN-1:0] target;
  logic            take;
  logic            wb;

  assign o_pop = i_not_empty & ~o_halt;

  assign rs_a = regs[i_q_ra]; // x0 stays zero, never written
  assign rs_b = regs[i_q_rb];
  assign op_a = (i_q_a_src == A_PC) ? pc : rs_a;

  always_comb begin
    case (i_q_b_src)
      B_IMM:   op_b = i_q_imm;
      B_FOUR:  op_b = XLEN'(4);
      default: op_b = rs_b;
    endcase
  end

  assign sum = op_a + op_b;

  always_comb begin
    case (i_q_alu_op)
      ALU_ADD:      alu_res = sum;
      ALU_ADDW:     alu_res = {{(XLEN - 32){sum[31]}}, sum[31:0]};
      ALU_SUB:      alu_res = op_a - op_b;
      ALU_SLTU:     alu_res = {{(XLEN - 1){1'b0}}, op_a < op_b};
      ALU_COPY_IMM: alu_res = op_b;
      default:      alu_res = '0; // ebreak and unknown
    endcase
  end

  always_comb begin
    case (i_q_branch)
      BR_JAL, BR_JALR: take = 1'b1;
      BR_EQ:           take = (rs_a == rs_b);
      BR_NE:           take = (rs_a != rs_b);
      default:         take = 1'b0;
    endcase
  end

  assign ea     = rs_a + i_q_imm; // Load/store address and jalr target
  assign target = (i_q_branch == BR_JALR) ? {ea[XLEN-1:1], 1'b0} : pc + i_q_imm;
  assign wb     = o_pop & i_q_reg_wr & (i_q_rd != '0);

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wb) begin
      regs[i_q_rd] <= alu_res;
    end
  end

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      pc       <= RESET_PC;
      o_retire <= 1'b0;
      o_wb_en  <= 1'b0;
      o_mem_wr <= 1'b0;
      o_mem_rd <= 1'b0;
      o_halt   <= 1'b0;
    end else begin
      o_retire <= o_pop;
      o_wb_en  <= wb;
      o_mem_wr <= o_pop & i_q_mem_wr;
      o_mem_rd <= o_pop & i_q_mem_rd;
      if (o_pop) begin
        pc <= take ? target : pc + XLEN'(4);
        if (i_q_alu_op == ALU_EBREAK) begin
          o_halt <= 1'b1; // Sticky until reset
        end
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (o_pop) begin
      o_retire_pc <= pc;
      o_wb_rd     <= i_q_rd;
      o_wb_data   <= alu_res;
      o_mem_addr  <= ea;
      o_mem_wdata <= rs_b;
      o_mem_op    <= i_q_mem_op;
    end
  end

  a_no_wb_x0: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    o_wb_en |-> (o_wb_rd != '0));

endmodule

// File: hw/inst_decode.sv
// Instruction decode stage
module inst_decode
  import isa_pkg::*;
  import core_pkg::*;
(
  input  logic                  i_clk,
  input  logic                  i_rst_n,
  input  logic [INST_W-1:0]     i_inst,
  input  logic                  i_inst_valid,
  output logic                  o_dec_valid,
  output logic [XLEN-1:0]       o_imm,
  output logic [REG_ADDR_W-1:0] o_ra,
  output logic [REG_ADDR_W-1:0] o_rb,
  output logic [REG_ADDR_W-1:0] o_rd,
  output alu_op_e               o_alu_op,
  output branch_e               o_branch,
  output mem_op_e               o_mem_op,
  output a_src_e                o_a_src,
  output b_src_e                o_b_src,
  output logic                  o_reg_wr,
  output logic                  o_mem_wr,
  output logic                  o_mem_rd
);

  logic [6:0]      opcode;
  logic [2:0]      funct3;
  logic [6:0]      funct7;
  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_u;
  logic [XLEN-1:0] imm_s;
  logic [XLEN-1:0] imm_b;
  logic [XLEN-1:0] imm_j;
  logic [XLEN-1:0] imm;
  imm_fmt_e        fmt;
  alu_op_e         alu_op;
  branch_e         branch;
  mem_op_e         mem_op;
  a_src_e          a_src;
  b_src_e          b_src;
  logic            reg_wr;

  assign opcode = i_inst[6:0];
  assign funct3 = i_inst[14:12];
  assign funct7 = i_inst[31:25];

  assign imm_i = {{52{i_inst[31]}}, i_inst[31:20]};
  assign imm_u = {{32{i_inst[31]}}, i_inst[31:12], 12'b0};
  assign imm_s = {{52{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
  assign imm_b = {{52{i_inst[31]}}, i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
  assign imm_j = {{44{i_inst[31]}}, i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};

  wire inst_lui    = (opcode == OP_LUI);
  wire inst_auipc  = (opcode == OP_AUIPC);
  wire inst_jal    = (opcode == OP_JAL);
  wire inst_jalr   = (opcode == OP_JALR) & (funct3 == 3'b000);
  wire inst_beq    = (opcode == OP_BRANCH) & (funct3 == 3'b000);
  wire inst_bne    = (opcode == OP_BRANCH) & (funct3 == 3'b001);
  wire inst_lw     = (opcode == OP_LOAD) & (funct3 == 3'b010);
  wire inst_sw     = (opcode == OP_STORE) & (funct3 == 3'b010);
  wire inst_sd     = (opcode == OP_STORE) & (funct3 == 3'b011);
  wire inst_addi   = (opcode == OP_IMM) & (funct3 == 3'b000);
  wire inst_sltiu  = (opcode == OP_IMM) & (funct3 == 3'b011);
  wire inst_addiw  = (opcode == OP_IMM32) & (funct3 == 3'b000);
  wire inst_add    = (opcode == OP_REG) & (funct3 == 3'b000) & (funct7 == 7'b0000000);
  wire inst_sub    = (opcode == OP_REG) & (funct3 == 3'b000) & (funct7 == 7'b0100000);
  wire inst_addw   = (opcode == OP_REG32) & (funct3 == 3'b000) & (funct7 == 7'b0000000);
  wire inst_ebreak = (opcode == OP_SYSTEM) & (funct3 == 3'b000) & i_inst[20]; // Not ecall

  wire type_r = inst_add | inst_sub | inst_addw;
  wire type_i = |{inst_lw, inst_addi, inst_sltiu, inst_addiw, inst_ebreak, inst_jalr};
  wire type_u = inst_lui | inst_auipc;
  wire type_s = inst_sw | inst_sd;
  wire type_b = inst_beq | inst_bne;
  wire type_j = inst_jal;

  always_comb begin
    if (type_i)      fmt = IMM_I;
    else if (type_u) fmt = IMM_U;
    else if (type_s) fmt = IMM_S;
    else if (type_b) fmt = IMM_B;
    else if (type_j) fmt = IMM_J;
    else             fmt = IMM_NONE; // R-type and unknown
  end

  always_comb begin
    case (fmt)
      IMM_I:   imm = imm_i;
      IMM_U:   imm = imm_u;
      IMM_S:   imm = imm_s;
      IMM_B:   imm = imm_b;
      IMM_J:   imm = imm_j;
      default: imm = '0;
    endcase
  end

  always_comb begin
    if (inst_lui)                                 alu_op = ALU_COPY_IMM;
    else if (inst_addiw | inst_addw)              alu_op = ALU_ADDW;
    else if (inst_sub | type_b)                   alu_op = ALU_SUB;
    else if (inst_sltiu)                          alu_op = ALU_SLTU;
    else if (inst_ebreak)                         alu_op = ALU_EBREAK;
    else if (|{inst_auipc, inst_jal, inst_jalr, inst_lw, type_s, inst_addi, inst_add})
      alu_op = ALU_ADD;
    else
      alu_op = ALU_NONE;
  end

  always_comb begin
    if (inst_jal)       branch = BR_JAL;
    else if (inst_jalr) branch = BR_JALR;
    else if (inst_beq)  branch = BR_EQ;
    else if (inst_bne)  branch = BR_NE;
    else                branch = BR_NONE;
  end

  assign mem_op = (inst_lw | inst_sw) ? MEM_W_S : (inst_sd ? MEM_D : MEM_NONE);
  assign a_src  = (inst_jal | inst_auipc | inst_jalr) ? A_PC : A_REG;
  assign b_src  = (inst_jal | inst_jalr) ? B_FOUR :
                  ((type_i | type_u | type_s) ? B_IMM : B_REG);
  // Loads return no data here, ebreak has no result
  assign reg_wr = |{type_r, type_u, type_j, inst_addi, inst_sltiu, inst_addiw, inst_jalr};

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      o_dec_valid <= 1'b0;
    end else begin
      o_dec_valid <= i_inst_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_inst_valid) begin
      o_imm    <= imm;
      o_ra     <= i_inst[19:15];
      o_rb     <= i_inst[24:20];
      o_rd     <= i_inst[11:7];
      o_alu_op <= alu_op;
      o_branch <= branch;
      o_mem_op <= mem_op;
      o_a_src  <= a_src;
      o_b_src  <= b_src;
      o_reg_wr <= reg_wr;
      o_mem_wr <= type_s;
      o_mem_rd <= inst_lw;
    end
  end

endmodule

// File: hw/isa_pkg.sv
// RV64I subset encodings
package isa_pkg;

  localparam int INST_W    = 32;
  localparam int OPCODE_W  = 7;
  localparam int ALU_OP_W  = 4;
  localparam int BRANCH_W  = 3;
  localparam int MEM_OP_W  = 3;
  localparam int IMM_FMT_W = 3;
  localparam int A_SRC_W   = 1;
  localparam int B_SRC_W   = 2;

  typedef enum logic [OPCODE_W-1:0] {
    OP_LUI    = 7'b0110111,
    OP_AUIPC  = 7'b0010111,
    OP_JAL    = 7'b1101111,
    OP_JALR   = 7'b1100111,
    OP_BRANCH = 7'b1100011,
    OP_LOAD   = 7'b0000011,
    OP_STORE  = 7'b0100011,
    OP_IMM    = 7'b0010011,
    OP_IMM32  = 7'b0011011,
    OP_REG    = 7'b0110011,
    OP_REG32  = 7'b0111011,
    OP_SYSTEM = 7'b1110011
  } opcode_e;

  typedef enum logic [ALU_OP_W-1:0] {
    ALU_ADD      = 4'b0000,
    ALU_COPY_IMM = 4'b0011,
    ALU_SUB      = 4'b1000,
    ALU_ADDW     = 4'b1001, // Add, then sign-extend low word
    ALU_SLTU     = 4'b1010,
    ALU_EBREAK   = 4'b1110,
    ALU_NONE     = 4'b1111
  } alu_op_e;

  typedef enum logic [BRANCH_W-1:0] {
    BR_NONE = 3'b000,
    BR_JAL  = 3'b001,
    BR_JALR = 3'b010,
    BR_EQ   = 3'b100,
    BR_NE   = 3'b101
  } branch_e;

  typedef enum logic [MEM_OP_W-1:0] {
    MEM_W_S  = 3'b100,
    MEM_D    = 3'b110,
    MEM_NONE = 3'b111
  } mem_op_e;

  typedef enum logic [IMM_FMT_W-1:0] {
    IMM_I    = 3'b000,
    IMM_U    = 3'b001,
    IMM_S    = 3'b010,
    IMM_B    = 3'b011,
    IMM_J    = 3'b100,
    IMM_NONE = 3'b111
  } imm_fmt_e;

  typedef enum logic [A_SRC_W-1:0] {
    A_REG = 1'b0,
    A_PC  = 1'b1
  } a_src_e;

  typedef enum logic [B_SRC_W-1:0] {
    B_REG  = 2'b00,
    B_IMM  = 2'b01,
    B_FOUR = 2'b10  // Return address PC+4
  } b_src_e;

endpackage

// File: tests/core_stimulus.txt
# I <inst> / R <pc> <wb_en> <rd> <data> / S <addr> <wdata> <mem_op> / L <addr> <mem_op>
# H means halt after the previous retire; I records after it never retire
I 123450B7
R 80000000 1 01 0000000012345000
I 67808113
R 80000004 1 02 0000000012345678
I FFF00193
R 80000008 1 03 FFFFFFFFFFFFFFFF
I 00310233
R 8000000C 1 04 0000000012345677
I 404102B3
R 80000010 1 05 0000000000000001
I 0022B313
R 80000014 1 06 0000000000000001
I 0051B393
R 80000018 1 07 0000000000000000
I 7FFFF437
R 8000001C 1 08 000000007FFFF000
I 008404BB
R 80000020 1 09 FFFFFFFFFFFFE000
I 00840533
R 80000024 1 0A 00000000FFFFE000
I 0015059B
R 80000028 1 0B FFFFFFFFFFFFE001
I 00510013
R 8000002C 0 00 0000000000000000
I 00001617
R 80000030 1 0C 0000000080001030
I 00C006EF
R 80000034 1 0D 0000000080000038
I 00628463
R 80000040 0 00 0000000000000000
I 00629863
R 80000048 0 00 0000000000000000
I 00729A63
R 8000004C 0 00 0000000000000000
I FE7314E3
R 80000060 0 00 0000000000000000
I 01060767
R 80000048 1 0E 000000008000004C
I 00262423
R 80001040 0 00 0000000000000000
S 0000000080001038 0000000012345678 4
I FE963823
R 80001044 0 00 0000000000000000
S 0000000080001020 FFFFFFFFFFFFE000 6
I 0040A783
R 80001048 0 00 0000000000000000
L 0000000012345004 4
I 0000000B
R 8000104C 0 00 0000000000000000
I 00278833
R 80001050 1 10 0000000012345678
I 005008B3
R 80001054 1 11 0000000000000001
I 00100073
R 80001058 0 00 0000000000000000
H
I 00108093
I 00210113
I FE963823
I 00100073

// File: tests/tb_core_top.sv
// Core slice testbench
module tb_core_top
  import isa_pkg::*;
  import core_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam logic [XLEN-1:0] RESET_PC    = DEF_RESET_PC;
  localparam int              QUEUE_DEPTH = DEF_QUEUE_DEPTH;
  localparam int              WAIT_LIMIT  = 100;
  localparam string           STIM_FILE   = "tests/core_stimulus.txt";

  logic                  i_clk;
  logic                  i_rst_n;
  logic [INST_W-1:0]     i_inst;
  logic                  i_inst_valid;
  logic                  o_ready;
  logic                  o_retire;
  logic [XLEN-1:0]       o_retire_pc;
  logic                  o_wb_en;
  logic [REG_ADDR_W-1:0] o_wb_rd;
  logic [XLEN-1:0]       o_wb_data;
  logic                  o_mem_wr;
  logic                  o_mem_rd;
  logic [XLEN-1:0]       o_mem_addr;
  logic [XLEN-1:0]       o_mem_wdata;
  mem_op_e               o_mem_op;
  logic                  o_halt;

  logic [INST_W-1:0]     drv_word [$];
  logic                  drv_halt [$]; // Marks a wait for o_halt
  logic [XLEN-1:0]       exp_pc [$];
  logic                  exp_wb_en [$];
  logic [REG_ADDR_W-1:0] exp_rd [$];
  logic [XLEN-1:0]       exp_data [$];
  logic [1:0]            exp_mem [$]; // 0 none, 1 store, 2 load
  logic [XLEN-1:0]       exp_addr [$];
  logic [XLEN-1:0]       exp_wdata [$];
  mem_op_e               exp_op [$];
  logic                  exp_halt [$];
  logic [31:0]           rng_state;

  core_top #(
    .RESET_PC    (RESET_PC),
    .QUEUE_DEPTH (QUEUE_DEPTH)
  ) DUT (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_inst       (i_inst),
    .i_inst_valid (i_inst_valid),
    .o_ready      (o_ready),
    .o_retire     (o_retire),
    .o_retire_pc  (o_retire_pc),
    .o_wb_en      (o_wb_en),
    .o_wb_rd      (o_wb_rd),
    .o_wb_data    (o_wb_data),
    .o_mem_wr     (o_mem_wr),
    .o_mem_rd     (o_mem_rd),
    .o_mem_addr   (o_mem_addr),
    .o_mem_wdata  (o_mem_wdata),
    .o_mem_op     (o_mem_op),
    .o_halt       (o_halt)
  );

  initial i_clk = 1'b0;
  always #4 i_clk = ~i_clk;

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("SOME TESTS FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic load_stimulus();
    int              fd;
    int              n;
    int              c;
    int              last;
    string           tag;
    logic [XLEN-1:0] f1;
    logic [XLEN-1:0] f2;
    logic [XLEN-1:0] f3;
    logic [XLEN-1:0] f4;
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) begin
      abort_run("Could not open the stimulus file");
    end else begin
      while ($fscanf(fd, "%s", tag) == 1) begin
        last = exp_pc.size() - 1;
        if (tag == "#") begin
          c = $fgetc(fd);
          while (c != 10 && c != -1) c = $fgetc(fd); // Rest of comment line
        end else if (tag == "I") begin
          n = $fscanf(fd, "%h", f1);
          if (n != 1) begin
            abort_run("Stimulus file has an instruction record with a missing field");
          end else begin
            drv_word.push_back(f1[INST_W-1:0]);
            drv_halt.push_back(1'b0);
          end
        end else if (tag == "R") begin
          n = $fscanf(fd, "%h %h %h %h", f1, f2, f3, f4);
          if (n != 4) begin
            abort_run("Stimulus file has a retire record with a missing field");
          end else begin
            exp_pc.push_back(f1);
            exp_wb_en.push_back(f2[0]);
            exp_rd.push_back(f3[REG_ADDR_W-1:0]);
            exp_data.push_back(f4);
            exp_mem.push_back(2'd0);
            exp_addr.push_back('0);
            exp_wdata.push_back('0);
            exp_op.push_back(MEM_NONE);
            exp_halt.push_back(1'b0);
          end
        end else if (last < 0) begin
          abort_run("Stimulus file has a record before its first retire record");
        end else if (tag == "S") begin
          n = $fscanf(fd, "%h %h %h", f1, f2, f3);
          if (n != 3) begin
            abort_run("Stimulus file has a store record with a missing field");
          end else begin
            exp_mem[last]   = 2'd1;
            exp_addr[last]  = f1;
            exp_wdata[last] = f2;
            exp_op[last]    = mem_op_e'(f3[MEM_OP_W-1:0]);
          end
        end else if (tag == "L") begin
          n = $fscanf(fd, "%h %h", f1, f2);
          if (n != 2) begin
            abort_run("Stimulus file has a load record with a missing field");
          end else begin
            exp_mem[last]  = 2'd2;
            exp_addr[last] = f1;
            exp_op[last]   = mem_op_e'(f2[MEM_OP_W-1:0]);
          end
        end else if (tag == "H") begin
          exp_halt[last] = 1'b1;
          drv_word.push_back('0);
          drv_halt.push_back(1'b1);
        end else begin
          abort_run({"Unknown record tag in the stimulus file: ", tag});
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic check_level(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      abort_run($sformatf("Fail %s expected %h got %h", name, exp, act));
    end
  endtask

  task automatic check_halt(input logic exp);
    check_level("o_halt", exp, o_halt);
  endtask

  task automatic check_retire(input logic [XLEN-1:0] e_pc, input logic e_wb,
                              input logic [REG_ADDR_W-1:0] e_rd,
                              input logic [XLEN-1:0] e_data);
    if (o_retire_pc !== e_pc) begin
      abort_run($sformatf("Fail o_retire_pc expected %h got %h", e_pc, o_retire_pc));
    end else if (o_wb_en !== e_wb) begin
      abort_run($sformatf("Fail o_wb_en expected %h got %h", e_wb, o_wb_en));
    end else if (e_wb && (o_wb_rd !== e_rd)) begin
      abort_run($sformatf("Fail o_wb_rd expected %h got %h", e_rd, o_wb_rd));
    end else if (e_wb && (o_wb_data !== e_data)) begin
      abort_run($sformatf("Fail o_wb_data expected %h got %h", e_data, o_wb_data));
    end
  endtask

  task automatic check_mem(input logic e_wr, input logic e_rd,
                           input logic [XLEN-1:0] e_addr, input logic [XLEN-1:0] e_wdata,
                           input mem_op_e e_op);
    if (o_mem_wr !== e_wr) begin
      abort_run($sformatf("Fail o_mem_wr expected %h got %h", e_wr, o_mem_wr));
    end else if (o_mem_rd !== e_rd) begin
      abort_run($sformatf("Fail o_mem_rd expected %h got %h", e_rd, o_mem_rd));
    end else if ((e_wr || e_rd) && (o_mem_addr !== e_addr)) begin
      abort_run($sformatf("Fail o_mem_addr expected %h got %h", e_addr, o_mem_addr));
    end else if ((e_wr || e_rd) && (o_mem_op !== e_op)) begin
      abort_run($sformatf("Fail o_mem_op expected %h got %h", e_op, o_mem_op));
    end else if (e_wr && (o_mem_wdata !== e_wdata)) begin
      abort_run($sformatf("Fail o_mem_wdata expected %h got %h", e_wdata, o_mem_wdata));
    end
  endtask

  task automatic wait_ready(input logic level);
    int n;
    n = 0;
    while (o_ready !== level) begin
      if (n == WAIT_LIMIT) begin
        if (level) abort_run("Timed out waiting for o_ready to rise");
        else abort_run("Timed out waiting for the queue to fill and o_ready to fall");
      end else begin
        @(posedge i_clk);
        #1;
        n++;
      end
    end
  endtask

  task automatic wait_halt();
    int n;
    n = 0;
    while (o_halt !== 1'b1) begin
      if (n == WAIT_LIMIT) begin
        abort_run("Timed out waiting for o_halt after ebreak");
      end else begin
        @(posedge i_clk);
        #1;
        n++;
      end
    end
  endtask

  // Drives a one-cycle strobe 1 ns after a rising edge
  task automatic send_inst(input logic [INST_W-1:0] word);
    wait_ready(1'b1);
    i_inst       = word;
    i_inst_valid = 1'b1;
    @(posedge i_clk);
    #1;
    i_inst_valid = 1'b0;
  endtask

  // Checks each retire in order against the expected records
  always @(negedge i_clk) begin
    if (i_rst_n === 1'b1) begin
      if (o_retire === 1'b1) begin
        if (exp_pc.size() == 0) begin
          abort_run("An instruction retired after the last expected retire");
        end else begin
          check_retire(exp_pc[0], exp_wb_en[0], exp_rd[0], exp_data[0]);
          check_mem(exp_mem[0] == 2'd1, exp_mem[0] == 2'd2, exp_addr[0], exp_wdata[0],
                    exp_op[0]);
          check_halt(exp_halt[0]);
          void'(exp_pc.pop_front());
          void'(exp_wb_en.pop_front());
          void'(exp_rd.pop_front());
          void'(exp_data.pop_front());
          void'(exp_mem.pop_front());
          void'(exp_addr.pop_front());
          void'(exp_wdata.pop_front());
          void'(exp_op.pop_front());
          void'(exp_halt.pop_front());
        end
      end else if (o_wb_en || o_mem_wr || o_mem_rd) begin
        abort_run("Writeback or memory request seen without a retire");
      end
    end
  end

  initial begin : main_flow
    int   idx;
    int   gap;
    logic halted;
    i_rst_n      = 1'b0;
    i_inst       = '0;
    i_inst_valid = 1'b0;
    rng_state    = 32'd44;
    halted       = 1'b0;
    load_stimulus();
    repeat (5) @(posedge i_clk);
    #1;
    i_rst_n = 1'b1;

    @(negedge i_clk);
    check_level("o_retire", 1'b0, o_retire);
    check_level("o_wb_en", 1'b0, o_wb_en);
    check_level("o_mem_wr", 1'b0, o_mem_wr);
    check_level("o_mem_rd", 1'b0, o_mem_rd);
    check_halt(1'b0);
    check_level("o_ready", 1'b1, o_ready);
    @(posedge i_clk);
    #1;

    for (idx = 0; idx < drv_word.size(); idx++) begin
      if (drv_halt[idx]) begin
        wait_halt();
        halted = 1'b1;
      end else begin
        if (halted) check_level("o_ready", 1'b1, o_ready); // Queue not yet full
        send_inst(drv_word[idx]);
        rng_state = xorshift32(rng_state);
        gap = int'(rng_state[1:0]);
        if (halted && gap == 0) gap = 1; // Let o_ready see the last push
        repeat (gap) begin
          @(posedge i_clk);
          #1;
        end
      end
    end

    wait_ready(1'b0);
    repeat (10) @(posedge i_clk);
    #1;
    check_level("o_ready", 1'b0, o_ready);
    check_halt(1'b1);
    if (exp_pc.size() != 0) begin
      abort_run("Not every expected instruction retired");
    end else begin
      $display("ALL TESTS PASSED");
      $finish;
    end
  end

endmodule
